// ==== common/parking_pkg.sv ====
// --------------------
// Floor 0 is the entry floor and holds no bays
// Plate zero is reserved to mark an empty bay
// --------------------
`default_nettype none

package parking_pkg;

	typedef logic [15:0] plate_t;
	typedef logic [2:0]  floor_t;

	// Floor in bits 3:1, side in bit 0 (0 left, 1 right)
	typedef logic [3:0]  bay_id_t;

	typedef logic [7:0]  fee_t;
	typedef logic [3:0]  count_t;

	localparam int NUM_FLOORS  = 7;
	localparam int NUM_BAYS    = 14;
	localparam int QUEUE_DEPTH = 8;

	// Top nibble of the plate selects the special classes
	localparam int DISABLED_CLASS = 9;
	localparam int HYBRID_CLASS   = 8;

	// Fee added per cycle parked
	localparam int RATE_DISABLED = 0;
	localparam int RATE_HYBRID   = 1;
	localparam int RATE_STANDARD = 2;

	localparam int FEE_MAX = 255;

	function automatic fee_t fee_rate(plate_t p);
		if (p[15:12] == 4'(DISABLED_CLASS)) begin
			return fee_t'(RATE_DISABLED);
		end
		if (p[15:12] == 4'(HYBRID_CLASS)) begin
			return fee_t'(RATE_HYBRID);
		end
		return fee_t'(RATE_STANDARD);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/request_fifo.sv ====
// --------------------
// Requests arriving while full or with both strobes high are lost
// --------------------
`timescale 1ns/100ps
`default_nettype none

module request_fifo import parking_pkg::*; #(
	parameter int DEPTH = QUEUE_DEPTH
) (
	input  logic   clock,
	input  logic   reset,
	input  logic   park_request,
	input  logic   retrieve_request,
	input  plate_t plate,
	input  logic   pop,
	output logic   job_available,
	output logic   job_is_retrieve,
	output plate_t job_plate,
	output logic   dropped
);

	localparam int PTR_W = $clog2(DEPTH);

	plate_t           plate_mem [DEPTH];
	logic             kind_mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             request;
	logic             full;
	logic             push;

	assign request = park_request | retrieve_request;
	assign full    = (count == (PTR_W + 1)'(DEPTH));
	// Exactly one strobe and room left
	assign push    = (park_request ^ retrieve_request) && !full;

	assign job_available   = (count != '0);
	assign job_is_retrieve = kind_mem[rd_ptr];
	assign job_plate       = plate_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr  <= '0;
			wr_ptr  <= '0;
			count   <= '0;
			dropped <= 1'b0;
		end else begin
			dropped <= request && !push;
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
		end
	end

	always_ff @(posedge clock) begin
		if (push) begin
			plate_mem[wr_ptr] <= plate;
			kind_mem[wr_ptr]  <= retrieve_request;
		end
	end

	// Planner only takes a job that is actually queued
	assert property (@(posedge clock) disable iff (reset) pop |-> job_available);

endmodule

`default_nettype wire

// ==== verilog/bay_planner.sv ====
// --------------------
// Decides one cycle after the pop, from the live occupant array
// --------------------
`timescale 1ns/100ps
`default_nettype none

module bay_planner import parking_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    job_available,
	input  logic    job_is_retrieve,
	input  plate_t  job_plate,
	input  logic    lift_idle,
	input  plate_t  occupant [NUM_BAYS],
	output logic    pop,
	output logic    trip_start,
	output bay_id_t trip_bay,
	output logic    trip_is_retrieve,
	output plate_t  trip_plate,
	output logic    rejected
);

	logic    pending;
	logic    job_is_retrieve_q;
	plate_t  job_plate_q;
	logic    hit;
	bay_id_t hit_bay;
	logic    odd_free;
	bay_id_t odd_bay;
	logic    even_free;
	bay_id_t even_bay;
	logic    is_suv;
	logic    park_ok;
	bay_id_t park_bay;
	logic    accept;

	assign pop = job_available && lift_idle && !pending;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= 1'b0;
		end else begin
			pending <= pop;
		end
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			job_is_retrieve_q <= job_is_retrieve;
			job_plate_q       <= job_plate;
		end
	end

	// Plate lookup, zero never matches since it marks an empty bay
	always_comb begin
		hit     = 1'b0;
		hit_bay = '0;
		for (int i = 0; i < NUM_BAYS; i++) begin
			if (!hit && job_plate_q != '0 && occupant[i] == job_plate_q) begin
				hit     = 1'b1;
				hit_bay = bay_id_t'(i + 2);
			end
		end
	end

	// Lowest free bay per floor parity, index order is floor then side
	always_comb begin
		odd_free  = 1'b0;
		odd_bay   = '0;
		even_free = 1'b0;
		even_bay  = '0;
		for (int i = 0; i < NUM_BAYS; i++) begin
			if (occupant[i] == '0) begin
				// Index pairs 0-1 sit on floor 1, 2-3 on floor 2 and so on
				if (((i / 2) % 2) == 0 && !odd_free) begin
					odd_free = 1'b1;
					odd_bay  = bay_id_t'(i + 2);
				end else if (((i / 2) % 2) == 1 && !even_free) begin
					even_free = 1'b1;
					even_bay  = bay_id_t'(i + 2);
				end
			end
		end
	end

	assign is_suv = job_plate_q[0];

	// Sedans spill onto odd floors only once the even floors are full
	assign park_ok  = is_suv ? odd_free : (even_free || odd_free);
	assign park_bay = (is_suv || !even_free) ? odd_bay : even_bay;

	assign accept = job_is_retrieve_q ? hit : (job_plate_q != '0 && !hit && park_ok);

	assign trip_start       = pending && accept;
	assign rejected         = pending && !accept;
	assign trip_bay         = job_is_retrieve_q ? hit_bay : park_bay;
	assign trip_is_retrieve = job_is_retrieve_q;
	assign trip_plate       = job_plate_q;

endmodule

`default_nettype wire

// ==== lift/lift_controller.sv ====
// --------------------
// One floor per cycle, always returns to floor 0 before the next trip
// --------------------
`timescale 1ns/100ps
`default_nettype none

module lift_controller import parking_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    trip_start,
	input  bay_id_t trip_bay,
	input  logic    trip_is_retrieve,
	input  plate_t  trip_plate,
	output logic    lift_idle,
	output floor_t  current_floor,
	output logic    done,
	output logic    done_is_retrieve,
	output bay_id_t done_bay,
	output plate_t  done_plate
);

	typedef enum logic [1:0] {
		IDLE,
		ASCEND,
		DESCEND
	} state_t;

	state_t  state;
	bay_id_t target_bay;
	logic    target_is_retrieve;
	plate_t  target_plate;
	floor_t  target_floor;

	assign target_floor = target_bay[3:1];

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= IDLE;
			current_floor <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (trip_start) begin
						state         <= ASCEND;
						current_floor <= floor_t'(1);
					end
				end
				ASCEND: begin
					if (current_floor == target_floor) begin
						// Store or pick happens this cycle, head back down
						current_floor <= current_floor - floor_t'(1);
						state         <= (current_floor == floor_t'(1)) ? IDLE : DESCEND;
					end else begin
						current_floor <= current_floor + floor_t'(1);
					end
				end
				DESCEND: begin
					current_floor <= current_floor - floor_t'(1);
					if (current_floor == floor_t'(1)) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Trip details held for the whole journey
	always_ff @(posedge clock) begin
		if (state == IDLE && trip_start) begin
			target_bay         <= trip_bay;
			target_is_retrieve <= trip_is_retrieve;
			target_plate       <= trip_plate;
		end
	end

	assign lift_idle        = (state == IDLE);
	assign done             = (state == ASCEND) && (current_floor == target_floor);
	assign done_is_retrieve = target_is_retrieve;
	assign done_bay         = target_bay;
	assign done_plate       = target_plate;

	// Planner must wait for the lift to come home
	assert property (@(posedge clock) disable iff (reset) trip_start |-> state == IDLE);

endmodule

`default_nettype wire

// ==== verilog/bay_store.sv ====
// --------------------
// Fee saturates at FEE_MAX and is reported the cycle after a pick
// --------------------
`timescale 1ns/100ps
`default_nettype none

module bay_store import parking_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    done,
	input  logic    done_is_retrieve,
	input  bay_id_t done_bay,
	input  plate_t  done_plate,
	output plate_t  occupant [NUM_BAYS],
	output fee_t    fee,
	output logic    fee_valid,
	output count_t  empty_suv,
	output count_t  empty_sedan
);

	fee_t       fee_count [NUM_BAYS];
	fee_t       fee_next [NUM_BAYS];
	logic [3:0] bay_index;
	logic       store;
	logic       pick;

	// Bay ids start at 2 on floor 1
	assign bay_index = done_bay - 4'd2;
	assign store     = done && !done_is_retrieve;
	assign pick      = done && done_is_retrieve;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_BAYS; i++) begin
				occupant[i] <= '0;
			end
		end else if (done) begin
			occupant[bay_index] <= done_is_retrieve ? '0 : done_plate;
		end
	end

	// Next fee per bay with saturation
	always_comb begin
		logic [8:0] sum;
		for (int i = 0; i < NUM_BAYS; i++) begin
			sum         = {1'b0, fee_count[i]} + {1'b0, fee_rate(occupant[i])};
			fee_next[i] = (sum > 9'(FEE_MAX)) ? fee_t'(FEE_MAX) : sum[7:0];
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < NUM_BAYS; i++) begin
			if (store && bay_index == 4'(i)) begin
				fee_count[i] <= '0;
			end else if (occupant[i] != '0) begin
				fee_count[i] <= fee_next[i];
			end
		end
	end

	// Pick cycle is charged too, so the fee is rate times the done distance
	always_ff @(posedge clock) begin
		if (pick) begin
			fee <= fee_next[bay_index];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fee_valid <= 1'b0;
		end else begin
			fee_valid <= pick;
		end
	end

	// Odd floors hold index pairs 0-1, 4-5, 8-9 and 12-13
	always_comb begin
		empty_suv   = '0;
		empty_sedan = '0;
		for (int i = 0; i < NUM_BAYS; i++) begin
			if (occupant[i] == '0) begin
				if (((i / 2) % 2) == 0) begin
					empty_suv = empty_suv + count_t'(1);
				end else begin
					empty_sedan = empty_sedan + count_t'(1);
				end
			end
		end
	end

	// Planner and lift together must never double park or pick from nothing
	assert property (@(posedge clock) disable iff (reset)
		store |-> occupant[bay_index] == '0);
	assert property (@(posedge clock) disable iff (reset)
		pick |-> occupant[bay_index] != '0);

endmodule

`default_nettype wire

// ==== verilog/parking_tower.sv ====
// --------------------
// Exactly one request strobe per cycle, one trip in flight at a time
// --------------------
`timescale 1ns/100ps
`default_nettype none

module parking_tower import parking_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    park_request,
	input  logic    retrieve_request,
	input  plate_t  plate,
	output logic    request_dropped,
	output logic    request_rejected,
	output logic    done,
	output bay_id_t done_bay,
	output fee_t    fee,
	output logic    fee_valid,
	output floor_t  current_floor,
	output logic    lift_idle,
	output count_t  empty_suv,
	output count_t  empty_sedan
);

	logic    job_available;
	logic    job_is_retrieve;
	plate_t  job_plate;
	logic    pop;
	logic    trip_start;
	bay_id_t trip_bay;
	logic    trip_is_retrieve;
	plate_t  trip_plate;
	logic    done_is_retrieve;
	plate_t  done_plate;
	plate_t  occupant [NUM_BAYS];

	request_fifo #(
		.DEPTH(QUEUE_DEPTH)
	) u_request_fifo (
		.clock           (clock),
		.reset           (reset),
		.park_request    (park_request),
		.retrieve_request(retrieve_request),
		.plate           (plate),
		.pop             (pop),
		.job_available   (job_available),
		.job_is_retrieve (job_is_retrieve),
		.job_plate       (job_plate),
		.dropped         (request_dropped)
	);

	bay_planner u_bay_planner (
		.clock           (clock),
		.reset           (reset),
		.job_available   (job_available),
		.job_is_retrieve (job_is_retrieve),
		.job_plate       (job_plate),
		.lift_idle       (lift_idle),
		.occupant        (occupant),
		.pop             (pop),
		.trip_start      (trip_start),
		.trip_bay        (trip_bay),
		.trip_is_retrieve(trip_is_retrieve),
		.trip_plate      (trip_plate),
		.rejected        (request_rejected)
	);

	lift_controller u_lift_controller (
		.clock           (clock),
		.reset           (reset),
		.trip_start      (trip_start),
		.trip_bay        (trip_bay),
		.trip_is_retrieve(trip_is_retrieve),
		.trip_plate      (trip_plate),
		.lift_idle       (lift_idle),
		.current_floor   (current_floor),
		.done            (done),
		.done_is_retrieve(done_is_retrieve),
		.done_bay        (done_bay),
		.done_plate      (done_plate)
	);

	bay_store u_bay_store (
		.clock           (clock),
		.reset           (reset),
		.done            (done),
		.done_is_retrieve(done_is_retrieve),
		.done_bay        (done_bay),
		.done_plate      (done_plate),
		.occupant        (occupant),
		.fee             (fee),
		.fee_valid       (fee_valid),
		.empty_suv       (empty_suv),
		.empty_sedan     (empty_sedan)
	);

endmodule

`default_nettype wire

// ==== sim/tb_parking_tower.sv ====
// --------------------
// Reference model tracks occupants, bay choice, fees and free counts
// Trips and rejections are collected at the falling edge
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_parking_tower
	import parking_pkg::*;
();

	// Several times the expected length of all tests together
	localparam int TIMEOUT_CYCLES = 4000;

	localparam int KIND_SEDAN    = 0;
	localparam int KIND_SUV      = 1;
	localparam int KIND_HYBRID   = 2;
	localparam int KIND_DISABLED = 3;

	logic    clock;
	logic    reset;
	logic    park_request;
	logic    retrieve_request;
	plate_t  plate;
	logic    request_dropped;
	logic    request_rejected;
	logic    done;
	bay_id_t done_bay;
	fee_t    fee;
	logic    fee_valid;
	floor_t  current_floor;
	logic    lift_idle;
	count_t  empty_suv;
	count_t  empty_sedan;

	// Reference model of the tower
	plate_t  model_occ [NUM_BAYS];
	int      park_cycle [NUM_BAYS];
	logic    pend_ret [$];
	plate_t  pend_plate [$];

	// Outcomes seen by the monitor, follow-up fields land one cycle later
	logic    ev_done [$];
	bay_id_t ev_bay [$];
	int      ev_cycle [$];
	logic    ev_fee_valid [$];
	fee_t    ev_fee [$];
	count_t  ev_suv [$];
	count_t  ev_sedan [$];

	logic [31:0] lfsr;
	int          errors;
	int          tests_run;
	int          cycle_count;
	logic        last_done;
	bay_id_t     last_bay;
	fee_t        last_fee;
	logic        follow_up;
	logic        was_idle;
	logic        climbing;
	floor_t      prev_floor;

	parking_tower DUT (
		.clock           (clock),
		.reset           (reset),
		.park_request    (park_request),
		.retrieve_request(retrieve_request),
		.plate           (plate),
		.request_dropped (request_dropped),
		.request_rejected(request_rejected),
		.done            (done),
		.done_bay        (done_bay),
		.fee             (fee),
		.fee_valid       (fee_valid),
		.current_floor   (current_floor),
		.lift_idle       (lift_idle),
		.empty_suv       (empty_suv),
		.empty_sedan     (empty_sedan)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count = cycle_count + 1;
		end
		$display("ERROR: timeout after %0d cycles, a test never saw its trip end", cycle_count);
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		$display("ERROR at %0t ns: %s", $time, msg);
	endtask

	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic random_bits(output plate_t v);
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
	endtask

	function automatic int class_rate(plate_t p);
		if (p[15:12] == 4'(DISABLED_CLASS)) begin
			return RATE_DISABLED;
		end
		if (p[15:12] == 4'(HYBRID_CLASS)) begin
			return RATE_HYBRID;
		end
		return RATE_STANDARD;
	endfunction

	function automatic bay_id_t find_bay(plate_t p);
		for (int b = 2; b < 16; b++) begin
			if (p != '0 && model_occ[b - 2] == p) begin
				return bay_id_t'(b);
			end
		end
		return '0;
	endfunction

	// Lowest floor of the given parity, left side first
	function automatic bay_id_t lowest_free(logic odd);
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (((f % 2) == 1) == odd && model_occ[f * 2 + s - 2] == '0) begin
					return bay_id_t'(f * 2 + s);
				end
			end
		end
		return '0;
	endfunction

	function automatic count_t free_count(logic odd);
		count_t n;
		n = '0;
		for (int f = 1; f <= NUM_FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (((f % 2) == 1) == odd && model_occ[f * 2 + s - 2] == '0) begin
					n = n + count_t'(1);
				end
			end
		end
		return n;
	endfunction

	// Sedans go to odd floors only when no even bay is left
	function automatic bay_id_t choose_bay(plate_t p);
		if (!p[0] && lowest_free(1'b0) != '0) begin
			return lowest_free(1'b0);
		end
		return lowest_free(1'b1);
	endfunction

	task automatic make_plate(input int kind, output plate_t p);
		logic fresh;
		fresh = 1'b0;
		while (!fresh) begin
			random_bits(p);
			if (kind == KIND_HYBRID) begin
				p[15:12] = 4'(HYBRID_CLASS);
			end else if (kind == KIND_DISABLED) begin
				p[15:12] = 4'(DISABLED_CLASS);
			end else begin
				if (p[15:12] == 4'h8 || p[15:12] == 4'h9) begin
					p[15:12] = p[15:12] ^ 4'h4;
				end
				p[0] = (kind == KIND_SUV);
			end
			fresh = (p != '0) && (find_bay(p) == '0);
			foreach (pend_plate[i]) begin
				if (pend_plate[i] == p) begin
					fresh = 1'b0;
				end
			end
		end
	endtask

	// Records outcomes, checks the climb and the arrival floor
	always @(negedge clock) begin
		if (reset) begin
			follow_up  = 1'b0;
			was_idle   = 1'b1;
			climbing   = 1'b0;
			prev_floor = '0;
		end else begin
			if (!follow_up && fee_valid) begin
				report_problem("fee_valid pulsed without a retrieve one cycle before");
			end
			if (follow_up) begin
				ev_fee_valid.push_back(fee_valid);
				ev_fee.push_back(fee);
				ev_suv.push_back(empty_suv);
				ev_sedan.push_back(empty_sedan);
				follow_up = 1'b0;
			end
			if (lift_idle && current_floor !== floor_t'(0)) begin
				report_mismatch("current_floor", 32'(current_floor), 32'(0));
			end
			if (!lift_idle && was_idle) begin
				climbing = 1'b1;
				if (current_floor !== floor_t'(1)) begin
					report_mismatch("current_floor", 32'(current_floor), 32'(1));
				end
			end else if (climbing && current_floor !== floor_t'(prev_floor + 3'd1)) begin
				report_mismatch("current_floor", 32'(current_floor), 32'(prev_floor + 3'd1));
			end
			if (done || request_rejected) begin
				if (done && request_rejected) begin
					report_problem("done and request_rejected high in the same cycle");
				end
				if (done && current_floor !== done_bay[3:1]) begin
					report_mismatch("current_floor", 32'(current_floor), 32'(done_bay[3:1]));
				end
				ev_done.push_back(done);
				ev_bay.push_back(done_bay);
				ev_cycle.push_back(cycle_count);
				follow_up = 1'b1;
			end
			if (done) begin
				climbing = 1'b0;
			end
			was_idle   = lift_idle;
			prev_floor = current_floor;
		end
	end

	task automatic issue(input logic park, input logic ret, input plate_t p,
			input logic expect_drop);
		park_request     = park;
		retrieve_request = ret;
		plate            = p;
		tick();
		park_request     = 1'b0;
		retrieve_request = 1'b0;
		plate            = '0;
		if (request_dropped !== expect_drop) begin
			report_mismatch("request_dropped", 32'(request_dropped), 32'(expect_drop));
		end
		if (!expect_drop) begin
			pend_ret.push_back(ret);
			pend_plate.push_back(p);
		end
	endtask

	// Takes the oldest request and checks its outcome against the model
	task automatic complete_next();
		logic    is_ret;
		plate_t  p;
		logic    expect_done;
		bay_id_t exp_bay;
		int      idx;
		int      at;
		int      exp_fee;
		logic    got_fee_valid;
		count_t  got_suv;
		count_t  got_sedan;
		is_ret = pend_ret.pop_front();
		p      = pend_plate.pop_front();
		if (is_ret) begin
			exp_bay     = find_bay(p);
			expect_done = (exp_bay != '0);
		end else begin
			exp_bay     = choose_bay(p);
			expect_done = (p != '0) && (find_bay(p) == '0) && (exp_bay != '0);
		end
		while (ev_sedan.size() == 0) begin
			tick();
		end
		last_done     = ev_done.pop_front();
		last_bay      = ev_bay.pop_front();
		at            = ev_cycle.pop_front();
		got_fee_valid = ev_fee_valid.pop_front();
		last_fee      = ev_fee.pop_front();
		got_suv       = ev_suv.pop_front();
		got_sedan     = ev_sedan.pop_front();
		if (last_done !== expect_done) begin
			if (expect_done) begin
				report_problem("request was rejected but a trip was expected");
			end else begin
				report_problem("lift made a trip for a request that should be rejected");
			end
		end else if (last_done && last_bay !== exp_bay) begin
			report_mismatch("done_bay", 32'(last_bay), 32'(exp_bay));
		end
		idx = int'(exp_bay) - 2;
		if (expect_done && is_ret) begin
			exp_fee = class_rate(p) * (at - park_cycle[idx]);
			if (exp_fee > FEE_MAX) begin
				exp_fee = FEE_MAX;
			end
			if (got_fee_valid !== 1'b1) begin
				report_problem("fee_valid did not pulse after a retrieve");
			end else if (last_fee !== fee_t'(exp_fee)) begin
				report_mismatch("fee", 32'(last_fee), 32'(exp_fee));
			end
			model_occ[idx] = '0;
		end else begin
			if (got_fee_valid !== 1'b0) begin
				report_problem("fee_valid pulsed after a park or a rejection");
			end
			if (expect_done) begin
				model_occ[idx]  = p;
				park_cycle[idx] = at;
			end
		end
		if (got_suv !== free_count(1'b1)) begin
			report_mismatch("empty_suv", 32'(got_suv), 32'(free_count(1'b1)));
		end
		if (got_sedan !== free_count(1'b0)) begin
			report_mismatch("empty_sedan", 32'(got_sedan), 32'(free_count(1'b0)));
		end
	endtask

	task automatic run_request(input logic park, input logic ret, input plate_t p);
		issue(park, ret, p, 1'b0);
		complete_next();
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d failing checks", name, errors - errs_before);
		end
	endtask

	task automatic test_reset_state();
		int errs;
		errs = errors;
		if (lift_idle !== 1'b1) begin
			report_mismatch("lift_idle", 32'(lift_idle), 32'(1));
		end
		if (current_floor !== floor_t'(0)) begin
			report_mismatch("current_floor", 32'(current_floor), 32'(0));
		end
		if (empty_suv !== count_t'(8)) begin
			report_mismatch("empty_suv", 32'(empty_suv), 32'(8));
		end
		if (empty_sedan !== count_t'(6)) begin
			report_mismatch("empty_sedan", 32'(empty_sedan), 32'(6));
		end
		if ({done, fee_valid, request_rejected, request_dropped} !== 4'b0000) begin
			report_mismatch("{done,fee_valid,request_rejected,request_dropped}",
				32'({done, fee_valid, request_rejected, request_dropped}), 32'(0));
		end
		close_test("reset state", errs);
	endtask

	task automatic test_single_car();
		int     errs;
		plate_t p;
		errs = errors;
		make_plate(KIND_SEDAN, p);
		run_request(1'b1, 1'b0, p);
		// Empty tower puts a sedan on floor 2 left
		if (last_bay !== bay_id_t'(4)) begin
			report_mismatch("done_bay", 32'(last_bay), 32'(4));
		end
		repeat (10) tick();
		run_request(1'b0, 1'b1, p);
		close_test("single standard car", errs);
	endtask

	task automatic test_allocation();
		int     errs;
		plate_t p;
		errs = errors;
		for (int i = 0; i < 7; i++) begin
			make_plate(KIND_SEDAN, p);
			run_request(1'b1, 1'b0, p);
		end
		// Seventh sedan overflows onto floor 1
		if (last_bay[3:1] !== floor_t'(1)) begin
			report_mismatch("done_bay floor", 32'(last_bay[3:1]), 32'(1));
		end
		for (int i = 0; i < 7; i++) begin
			make_plate(KIND_SUV, p);
			run_request(1'b1, 1'b0, p);
		end
		close_test("allocation", errs);
	endtask

	task automatic test_rejections();
		int     errs;
		count_t suv_before;
		count_t sedan_before;
		plate_t p;
		errs = errors;
		// One free SUV bay, so a sedan could still overflow into it
		run_request(1'b0, 1'b1, model_occ[13]);
		suv_before   = empty_suv;
		sedan_before = empty_sedan;
		make_plate(KIND_SEDAN, p);
		run_request(1'b0, 1'b1, p);
		if (last_done !== 1'b0) begin
			report_problem("retrieve of an unknown plate was not rejected");
		end
		run_request(1'b1, 1'b0, model_occ[0]);
		if (last_done !== 1'b0) begin
			report_problem("duplicate park was not rejected");
		end
		run_request(1'b1, 1'b0, '0);
		if (last_done !== 1'b0) begin
			report_problem("park of plate zero was not rejected");
		end
		if (empty_suv !== suv_before || empty_sedan !== sedan_before) begin
			report_problem("a rejected request changed the free-bay counts");
		end
		// Refill the free bay, then a new SUV has nowhere to go
		make_plate(KIND_SUV, p);
		run_request(1'b1, 1'b0, p);
		make_plate(KIND_SUV, p);
		run_request(1'b1, 1'b0, p);
		if (last_done !== 1'b0) begin
			report_problem("park into a full tower was not rejected");
		end
		close_test("rejections", errs);
	endtask

	task automatic test_queue();
		int     errs;
		plate_t p;
		errs = errors;
		// Floor 7 trip keeps the lift busy while the queue fills
		issue(1'b0, 1'b1, model_occ[12], 1'b0);
		issue(1'b0, 1'b1, model_occ[13], 1'b0);
		issue(1'b0, 1'b1, model_occ[11], 1'b0);
		make_plate(KIND_SUV, p);
		// Both strobes while the queue still has room
		issue(1'b1, 1'b1, p, 1'b1);
		issue(1'b1, 1'b0, p, 1'b0);
		make_plate(KIND_SEDAN, p);
		issue(1'b1, 1'b0, p, 1'b0);
		issue(1'b0, 1'b1, model_occ[0], 1'b0);
		issue(1'b0, 1'b1, model_occ[2], 1'b0);
		issue(1'b0, 1'b1, model_occ[4], 1'b0);
		make_plate(KIND_SEDAN, p);
		issue(1'b1, 1'b0, p, 1'b0);
		// Eight pending now
		make_plate(KIND_SUV, p);
		issue(1'b1, 1'b0, p, 1'b1);
		while (pend_ret.size() > 0) begin
			complete_next();
		end
		close_test("queue order and drops", errs);
	endtask

	task automatic test_fee_classes();
		int     errs;
		plate_t p;
		errs = errors;
		make_plate(KIND_HYBRID, p);
		run_request(1'b1, 1'b0, p);
		repeat (20) tick();
		run_request(1'b0, 1'b1, p);
		make_plate(KIND_DISABLED, p);
		run_request(1'b1, 1'b0, p);
		repeat (20) tick();
		run_request(1'b0, 1'b1, p);
		if (last_fee !== fee_t'(0)) begin
			report_mismatch("fee", 32'(last_fee), 32'(0));
		end
		make_plate(KIND_SEDAN, p);
		run_request(1'b1, 1'b0, p);
		repeat (140) tick();
		run_request(1'b0, 1'b1, p);
		if (last_fee !== fee_t'(FEE_MAX)) begin
			report_mismatch("fee", 32'(last_fee), 32'(FEE_MAX));
		end
		close_test("fee classes", errs);
	endtask

	initial begin
		lfsr             = 32'h03a6_5285;
		errors           = 0;
		tests_run        = 0;
		reset            = 1'b1;
		park_request     = 1'b0;
		retrieve_request = 1'b0;
		plate            = '0;
		for (int i = 0; i < NUM_BAYS; i++) begin
			model_occ[i]  = '0;
			park_cycle[i] = 0;
		end
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
		test_reset_state();
		test_single_car();
		test_allocation();
		test_rejections();
		test_queue();
		test_fee_classes();
		if (ev_done.size() != 0 || pend_ret.size() != 0) begin
			report_problem("trips or rejections left unmatched at the end of the run");
		end
		$display("Tests run: %0d, failing checks: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/parking_pkg.sv
verilog/request_fifo.sv
verilog/bay_planner.sv
lift/lift_controller.sv
verilog/bay_store.sv
verilog/parking_tower.sv
sim/tb_parking_tower.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_parking_tower -f compile.f -o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	&& grep -q "Simulation passed" sim.log \
	|| { echo "run failed, see build.log and sim.log"; exit 1; }
echo "run passed"
